/* hdl/cpuPkg.sv */
package cpuPkg;

    // ------------------------------------------------------------------------
    // Widths and reset values
    // ------------------------------------------------------------------------
    localparam int dataW  = 16;
    localparam int byteW  = 8;
    localparam int flagsW = 12;

    localparam logic [dataW-1:0] resetIp = 16'hFFF0;   // Fetch address after reset

    // Bit positions in the flags word
    localparam int flagCf = 0;
    localparam int flagPf = 2;
    localparam int flagAf = 4;
    localparam int flagZf = 6;
    localparam int flagSf = 7;
    localparam int flagTf = 8;
    localparam int flagIf = 9;
    localparam int flagDf = 10;
    localparam int flagOf = 11;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef logic [2:0] regIdxT;   // AX CX DX BX SP BP SI DI / AL CL DL BL AH CH DH BH

    typedef enum logic [2:0] {
        aluAdd, aluOr, aluAdc, aluSbb, aluAnd, aluSub, aluXor, aluCmp
    } aluOpT;

    typedef enum logic [2:0] {
        flgKeep, flgLoadAlu, flgClrCf, flgSetCf, flgCmpCf, flgSetIfBit, flgSetDfBit
    } flagOpT;

    typedef enum logic [3:0] {
        clsNop, clsMovImm, clsAluImm, clsIncDec, clsJcc,
        clsJmp8, clsFlag, clsCbwCwd, clsPortIn, clsPortOut
    } insClassT;

    typedef struct packed {
        insClassT   insClass;
        aluOpT      aluOp;
        logic       wide;      // Word operation
        regIdxT     regNum;
        logic [2:0] condSel;   // x86 condition number
        logic       condInv;
        flagOpT     flagOp;
        logic       portDx;    // Port address from DX instead of imm8
    } decodedT;

    typedef struct packed {
        logic             en;
        regIdxT           regNum;
        logic             wide;
        logic [dataW-1:0] data;
    } regWriteT;

    typedef struct packed {
        logic [dataW-1:0] portAddr;
        logic [dataW-1:0] portOut;
        logic             portWide;
        logic             portWrite;
        logic             portRead;
    } portBusT;

endpackage

/* hdl/regFile.sv */
`timescale 1ns/1ns

module regFile
    import cpuPkg::*;
(
    input  logic             clk25,
    input  logic             reset,
    input  regIdxT           regSel,
    input  logic             regWide,
    output logic [dataW-1:0] selValue,
    output logic [dataW-1:0] axValue,
    input  regWriteT         regWrite
);

    logic [dataW-1:0] regs [8];
    regIdxT           readIdx;    // Word holding the selected byte
    regIdxT           wordIdx;    // Word holding the written byte
    logic [byteW-1:0] keptHalf;   // Half that a byte write must leave alone

    assign readIdx  = {1'b0, regSel[1:0]};
    assign wordIdx  = {1'b0, regWrite.regNum[1:0]};
    assign keptHalf = regWrite.regNum[2] ? regs[wordIdx][7:0] : regs[wordIdx][15:8];
    assign axValue  = regs[0];

    // Numbers 4..7 at byte width are the high halves of AX..BX
    always_comb begin
        if (regWide)
            selValue = regs[regSel];
        else if (regSel[2])
            selValue = {{byteW{1'b0}}, regs[readIdx][15:8]};
        else
            selValue = {{byteW{1'b0}}, regs[readIdx][7:0]};
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (regWrite.en) begin
            if (regWrite.wide)
                regs[regWrite.regNum] <= regWrite.data;
            else if (regWrite.regNum[2])
                regs[wordIdx][15:8] <= regWrite.data[7:0];   // AH..BH
            else
                regs[wordIdx][7:0] <= regWrite.data[7:0];    // AL..BL
        end
    end

    byteWriteKeepsOtherHalf: assert property (@(posedge clk25) disable iff (reset)
        regWrite.en && !regWrite.wide |=>
            (($past(regWrite.regNum[2]) ? regs[$past(wordIdx)][7:0]
                                        : regs[$past(wordIdx)][15:8]) == $past(keptHalf)));

endmodule

/* hdl/aluUnit.sv */
`timescale 1ns/1ns

module aluUnit
    import cpuPkg::*;
(
    input  logic [dataW-1:0]  aluA,
    input  logic [dataW-1:0]  aluB,
    input  aluOpT             aluOp,
    input  logic              aluWide,
    input  logic              carryIn,
    input  logic [flagsW-1:0] flagsIn,
    output logic [dataW:0]    aluResult,
    output logic [flagsW-1:0] aluFlags
);

    logic [dataW-1:0] srcA;
    logic [dataW-1:0] srcB;
    logic             cin;
    logic             isLogic;
    logic             isSub;
    logic             isAdd;
    logic             signA;
    logic             signB;
    logic             signR;
    logic             carry;
    logic             overflow;

    // Byte operations see zero-extended operands
    assign srcA = aluWide ? aluA : {{byteW{1'b0}}, aluA[byteW-1:0]};
    assign srcB = aluWide ? aluB : {{byteW{1'b0}}, aluB[byteW-1:0]};

    assign cin     = (aluOp == aluAdc || aluOp == aluSbb) && carryIn;
    assign isLogic = aluOp inside {aluOr, aluAnd, aluXor};
    assign isSub   = aluOp inside {aluSub, aluSbb, aluCmp};
    assign isAdd   = aluOp inside {aluAdd, aluAdc};

    always_comb begin
        unique case (aluOp)
            aluAdd, aluAdc:         aluResult = {1'b0, srcA} + {1'b0, srcB} + {16'd0, cin};
            aluSub, aluSbb, aluCmp: aluResult = {1'b0, srcA} - {1'b0, srcB} - {16'd0, cin};
            aluOr:                  aluResult = {1'b0, srcA | srcB};
            aluAnd:                 aluResult = {1'b0, srcA & srcB};
            aluXor:                 aluResult = {1'b0, srcA ^ srcB};
        endcase
    end

    assign signA = aluWide ? srcA[15] : srcA[7];
    assign signB = aluWide ? srcB[15] : srcB[7];
    assign signR = aluWide ? aluResult[15] : aluResult[7];
    assign carry = aluWide ? aluResult[16] : aluResult[8];   // Borrow for subtraction

    // Sign of the result disagrees with what the operand signs allow
    assign overflow = isSub ? (signA ^ signB) & (signA ^ signR) :
                      isAdd ? (signA ~^ signB) & (signA ^ signR) : 1'b0;

    always_comb begin
        aluFlags         = '0;
        aluFlags[1]      = 1'b1;                        // Always one on x86
        aluFlags[flagTf] = flagsIn[flagTf];
        aluFlags[flagIf] = flagsIn[flagIf];
        aluFlags[flagDf] = flagsIn[flagDf];
        aluFlags[flagCf] = carry;
        aluFlags[flagOf] = overflow;
        aluFlags[flagAf] = !isLogic && (srcA[4] ^ srcB[4] ^ aluResult[4]);
        aluFlags[flagSf] = signR;
        aluFlags[flagZf] = aluWide ? (aluResult[15:0] == '0) : (aluResult[7:0] == '0);
        aluFlags[flagPf] = ~^aluResult[7:0];            // Low byte only
    end

    always_comb begin
        logicOpsClearCarry: assert (!isLogic || !(aluFlags[flagCf] || aluFlags[flagOf]));
    end

endmodule

/* hdl/flagUnit.sv */
`timescale 1ns/1ns

module flagUnit
    import cpuPkg::*;
(
    input  logic              clk25,
    input  logic              reset,
    input  flagOpT            flagOp,
    input  logic [flagsW-1:0] aluFlags,
    input  logic              setBit,     // New IF/DF value, low opcode bit
    input  logic [3:0]        condSel,    // {invert, condition}
    output logic [flagsW-1:0] flags,
    output logic              jumpTaken
);

    logic cond;

    always_ff @(posedge clk25) begin
        if (reset) begin
            flags <= 12'h002;
        end else begin
            case (flagOp)
                flgLoadAlu:  flags <= aluFlags;
                flgClrCf:    flags[flagCf] <= 1'b0;
                flgSetCf:    flags[flagCf] <= 1'b1;
                flgCmpCf:    flags[flagCf] <= ~flags[flagCf];
                flgSetIfBit: flags[flagIf] <= setBit;
                flgSetDfBit: flags[flagDf] <= setBit;
                default:     flags <= flags;
            endcase
        end
    end

    // x86 condition order O, B, Z, BE, S, P, L, LE
    always_comb begin
        unique case (condSel[2:0])
            3'd0: cond = flags[flagOf];
            3'd1: cond = flags[flagCf];
            3'd2: cond = flags[flagZf];
            3'd3: cond = flags[flagCf] | flags[flagZf];
            3'd4: cond = flags[flagSf];
            3'd5: cond = flags[flagPf];
            3'd6: cond = flags[flagSf] ^ flags[flagOf];
            3'd7: cond = (flags[flagSf] ^ flags[flagOf]) | flags[flagZf];
        endcase
    end

    assign jumpTaken = cond ^ condSel[3];

endmodule

/* hdl/opDecoder.sv */
`timescale 1ns/1ns

module opDecoder
    import cpuPkg::*;
(
    input  logic [byteW-1:0] opcode,
    output decodedT          decoded
);

    always_comb begin
        decoded = '0;   // Unmatched opcodes run as NOP

        casez (opcode)
            8'b00???10?: begin                      // ALU AL/AX, imm
                decoded.insClass = clsAluImm;
                decoded.aluOp    = aluOpT'(opcode[5:3]);
                decoded.wide     = opcode[0];
                decoded.flagOp   = flgLoadAlu;
            end
            8'b0100????: begin                      // INC/DEC r16
                decoded.insClass = clsIncDec;
                decoded.aluOp    = opcode[3] ? aluSub : aluAdd;
                decoded.wide     = 1'b1;
                decoded.regNum   = opcode[2:0];
                decoded.flagOp   = flgLoadAlu;
            end
            8'b0111????: begin                      // Jcc rel8
                decoded.insClass = clsJcc;
                decoded.condSel  = opcode[3:1];
                decoded.condInv  = opcode[0];
            end
            8'b1011????: begin                      // MOV reg, imm
                decoded.insClass = clsMovImm;
                decoded.wide     = opcode[3];
                decoded.regNum   = opcode[2:0];
            end
            8'b1001100?: begin                      // CBW writes AX, CWD writes DX
                decoded.insClass = clsCbwCwd;
                decoded.wide     = 1'b1;
                decoded.regNum   = opcode[0] ? 3'd2 : 3'd0;
            end
            8'b11101011: decoded.insClass = clsJmp8;
            8'b1110?1??: begin                      // IN/OUT imm8 or DX
                decoded.insClass = opcode[1] ? clsPortOut : clsPortIn;
                decoded.wide     = opcode[0];
                decoded.portDx   = opcode[3];
            end
            8'b11110101: begin
                decoded.insClass = clsFlag;
                decoded.flagOp   = flgCmpCf;
            end
            8'b1111100?: begin
                decoded.insClass = clsFlag;
                decoded.flagOp   = opcode[0] ? flgSetCf : flgClrCf;
            end
            8'b1111101?: begin
                decoded.insClass = clsFlag;
                decoded.flagOp   = flgSetIfBit;
            end
            8'b1111110?: begin
                decoded.insClass = clsFlag;
                decoded.flagOp   = flgSetDfBit;
            end
            default: decoded.insClass = clsNop;
        endcase
    end

endmodule

/* hdl/execSequencer.sv */
`timescale 1ns/1ns

module execSequencer
    import cpuPkg::*;
(
    input  logic             clk25,
    input  logic             reset,
    input  logic [byteW-1:0] memData,
    input  decodedT          decoded,
    output logic [byteW-1:0] opcode,
    output logic [dataW-1:0] memAddr,
    input  logic [dataW-1:0] selValue,
    input  logic [dataW-1:0] axValue,
    output regIdxT           regSel,
    output logic             regWide,
    output regWriteT         regWrite,
    output logic [dataW-1:0] aluA,
    output logic [dataW-1:0] aluB,
    output aluOpT            aluOp,
    output logic             aluWide,
    input  logic [dataW:0]   aluResult,
    output flagOpT           flagOp,
    output logic [3:0]       condSel,
    input  logic             jumpTaken,
    input  logic [dataW-1:0] portIn,
    output portBusT          ioReq
);

    typedef enum logic {stFetch, stExec} stateT;

    stateT            state;
    logic [1:0]       step;          // Micro-step inside execute
    logic [1:0]       lastStep;
    logic             finalStep;
    logic             consumeByte;   // memData holds an operand byte
    logic             portClass;
    logic [dataW-1:0] ip;
    logic [dataW-1:0] jumpOffset;
    logic [byteW-1:0] latchedOp;
    logic [dataW-1:0] opA;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] portAddrQ;
    logic [dataW-1:0] portOutQ;
    logic             portWideQ;
    logic             portWrQ;
    logic             portRdQ;

    // Decode the bus byte while fetching, the latched opcode afterwards
    assign opcode    = (state == stFetch) ? memData : latchedOp;
    assign memAddr   = ip;
    assign portClass = decoded.insClass inside {clsPortIn, clsPortOut};
    assign regSel    = portClass ? 3'd2 : decoded.regNum;   // DX for port address
    assign regWide   = portClass | decoded.wide;
    assign aluA      = opA;
    assign aluB      = opB;
    assign aluOp     = decoded.aluOp;
    assign aluWide   = decoded.wide;
    assign condSel   = {decoded.condInv, decoded.condSel};
    assign ioReq     = '{portAddr: portAddrQ, portOut: portOutQ, portWide: portWideQ,
                         portWrite: portWrQ, portRead: portRdQ};

    assign finalStep  = (state == stExec) && (step == lastStep);
    assign jumpOffset = (decoded.insClass == clsJmp8 ||
                         (decoded.insClass == clsJcc && jumpTaken)) ?
                        {{byteW{memData[7]}}, memData} : '0;

    // ------------------------------------------------------------------------
    // Step counts per instruction class
    // ------------------------------------------------------------------------
    always_comb begin
        lastStep    = 2'd0;
        consumeByte = 1'b0;
        case (decoded.insClass)
            clsMovImm: begin
                lastStep    = {1'b0, decoded.wide};
                consumeByte = 1'b1;
            end
            clsAluImm: begin
                lastStep    = decoded.wide ? 2'd2 : 2'd1;
                consumeByte = (step == 2'd0) || (step == 2'd1 && decoded.wide);
            end
            clsIncDec:      lastStep = 2'd1;
            clsJcc, clsJmp8: consumeByte = 1'b1;   // Displacement byte
            clsPortOut: begin
                lastStep    = 2'd2;
                consumeByte = (step == 2'd0) && !decoded.portDx;
            end
            clsPortIn: begin
                lastStep    = 2'd3;                // Gives the device two cycles
                consumeByte = (step == 2'd0) && !decoded.portDx;
            end
            default: lastStep = 2'd0;
        endcase
    end

    always_comb begin
        flagOp = flgKeep;
        if ((state == stFetch && decoded.insClass == clsFlag) ||
            (finalStep && decoded.insClass inside {clsAluImm, clsIncDec}))
            flagOp = decoded.flagOp;
    end

    always_comb begin
        regWrite.en     = 1'b0;
        regWrite.regNum = decoded.regNum;
        regWrite.wide   = decoded.wide;
        regWrite.data   = aluResult[dataW-1:0];
        if (finalStep) begin
            case (decoded.insClass)
                clsMovImm: begin
                    regWrite.en   = 1'b1;
                    regWrite.data = decoded.wide ? {memData, opB[7:0]}
                                                 : {{byteW{1'b0}}, memData};
                end
                clsAluImm: regWrite.en = (decoded.aluOp != aluCmp);   // CMP: flags only
                clsIncDec: regWrite.en = 1'b1;
                clsCbwCwd: begin
                    regWrite.en   = 1'b1;
                    regWrite.data = latchedOp[0] ? {dataW{axValue[15]}}
                                                 : {{byteW{axValue[7]}}, axValue[7:0]};
                end
                clsPortIn: begin
                    regWrite.en   = 1'b1;
                    regWrite.data = portIn;
                end
                default: regWrite.en = 1'b0;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Control state, IP and port strobes
    // ------------------------------------------------------------------------
    always_ff @(posedge clk25) begin
        if (reset) begin
            state   <= stFetch;
            step    <= '0;
            ip      <= resetIp;
            portWrQ <= 1'b0;
            portRdQ <= 1'b0;
        end else begin
            portWrQ <= state == stExec && decoded.insClass == clsPortOut && step == 2'd1;
            portRdQ <= state == stExec && decoded.insClass == clsPortIn && step == 2'd0;
            if (state == stFetch) begin
                ip   <= ip + 16'd1;
                step <= '0;
                if (!(decoded.insClass inside {clsNop, clsFlag}))
                    state <= stExec;
            end else begin
                ip   <= ip + {{(dataW-1){1'b0}}, consumeByte} + jumpOffset;
                step <= step + 2'd1;
                if (finalStep)
                    state <= stFetch;
            end
        end
    end

    // Operand and port latches
    always_ff @(posedge clk25) begin
        if (state == stFetch) begin
            latchedOp <= memData;
        end else if (step == 2'd0) begin
            opA       <= selValue;                                   // AL/AX or INC/DEC reg
            opB       <= (decoded.insClass == clsIncDec) ? 16'd1 : {{byteW{1'b0}}, memData};
            portAddrQ <= decoded.portDx ? selValue : {{byteW{1'b0}}, memData};
            portOutQ  <= axValue;
            portWideQ <= decoded.wide;
        end else if (step == 2'd1 && decoded.wide) begin
            opB[15:8] <= memData;                                    // High immediate byte
        end
    end

    strobesExclusive: assert property (@(posedge clk25) disable iff (reset)
        !(portWrQ && portRdQ));

    writeStrobeOneCycle: assert property (@(posedge clk25) disable iff (reset)
        $rose(portWrQ) |=> !portWrQ);

    readStrobeOneCycle: assert property (@(posedge clk25) disable iff (reset)
        $rose(portRdQ) |=> !portRdQ);

endmodule

/* hdl/cpuCore.sv */
`timescale 1ns/1ns

module cpuCore
    import cpuPkg::*;
(
    input  logic             clk25,
    input  logic             reset,
    input  logic [byteW-1:0] memData,
    output logic [dataW-1:0] memAddr,
    input  logic [dataW-1:0] portIn,
    output portBusT          ioReq
);

    decodedT           decoded;
    logic [byteW-1:0]  opcode;
    logic [dataW-1:0]  selValue;
    logic [dataW-1:0]  axValue;
    regIdxT            regSel;
    logic              regWide;
    regWriteT          regWrite;
    logic [dataW-1:0]  aluA;
    logic [dataW-1:0]  aluB;
    aluOpT             aluOp;
    logic              aluWide;
    logic [dataW:0]    aluResult;
    logic [flagsW-1:0] aluFlags;
    flagOpT            flagOp;
    logic [3:0]        condSel;
    logic              jumpTaken;
    logic [flagsW-1:0] flags;

    opDecoder opDecoder_i (.opcode(opcode), .decoded(decoded));

    execSequencer execSequencer_i (
        .clk25(clk25), .reset(reset), .memData(memData), .decoded(decoded),
        .opcode(opcode), .memAddr(memAddr), .selValue(selValue), .axValue(axValue),
        .regSel(regSel), .regWide(regWide), .regWrite(regWrite),
        .aluA(aluA), .aluB(aluB), .aluOp(aluOp), .aluWide(aluWide),
        .aluResult(aluResult), .flagOp(flagOp), .condSel(condSel),
        .jumpTaken(jumpTaken), .portIn(portIn), .ioReq(ioReq)
    );

    regFile regFile_i (
        .clk25(clk25), .reset(reset), .regSel(regSel), .regWide(regWide),
        .selValue(selValue), .axValue(axValue), .regWrite(regWrite)
    );

    aluUnit aluUnit_i (
        .aluA(aluA), .aluB(aluB), .aluOp(aluOp), .aluWide(aluWide),
        .carryIn(flags[flagCf]), .flagsIn(flags),
        .aluResult(aluResult), .aluFlags(aluFlags)
    );

    // Low opcode bit carries the new IF/DF value
    flagUnit flagUnit_i (
        .clk25(clk25), .reset(reset), .flagOp(flagOp), .aluFlags(aluFlags),
        .setBit(opcode[0]), .condSel(condSel), .flags(flags), .jumpTaken(jumpTaken)
    );

endmodule

/* tb/progRom.sv */
`timescale 1ns/1ns

module progRom (
    input  logic [15:0] addr,
    output logic [7:0]  data
);

    localparam int progLen = 234;

    // Test program from offset 00, one line per group of instructions
    localparam logic [7:0] progCode [progLen] = '{
        8'hB8, 8'h34, 8'h12, 8'hE6, 8'h10, 8'hB4, 8'hAB, 8'hE7, 8'h11, 8'hB0, 8'h85, 8'h98,
        8'hE7, 8'h12, 8'h99, 8'hEF, 8'hB0, 8'h12, 8'h98, 8'h99, 8'hEF, 8'hBA, 8'h40, 8'h01,
        8'hEF,
        8'hB8, 8'hF0, 8'h00, 8'h04, 8'h20, 8'hE7, 8'h20, 8'h05, 8'hF0, 8'h0F, 8'hE7, 8'h21,
        8'h0C, 8'h5A, 8'hE7, 8'h22, 8'h0D, 8'h00, 8'h20, 8'hE7, 8'h23, 8'hF9, 8'h14, 8'h01,
        8'hE7, 8'h24, 8'hF9, 8'h15, 8'h00, 8'h01, 8'hE7, 8'h25, 8'hF8, 8'h1C, 8'h60,
        8'hE7, 8'h26, 8'h1D, 8'h00, 8'h01, 8'hE7, 8'h27, 8'h24, 8'h0F, 8'hE7, 8'h28,
        8'h25, 8'hF0, 8'hFF, 8'hE7, 8'h29, 8'h2C, 8'h01, 8'hE7, 8'h2A,
        8'h2D, 8'hFF, 8'h00, 8'hE7, 8'h2B, 8'h34, 8'hA5, 8'hE7, 8'h2C,
        8'h35, 8'hA5, 8'h30, 8'hE7, 8'h2D, 8'h3C, 8'h01, 8'hE7, 8'h2E,
        8'h3D, 8'h00, 8'h80, 8'hE7, 8'h2F, 8'h48, 8'hE7, 8'h30,             // DEC AX at 67
        8'h72, 8'h02, 8'hE7, 8'hEE, 8'h40, 8'hE7, 8'h31, 8'h73, 8'h02, 8'hE7, 8'h32,
        8'hB8, 8'h05, 8'h00, 8'h3D, 8'h03, 8'h00,                           // All conditions false
        8'h70, 8'h10, 8'h72, 8'h0E, 8'h74, 8'h0C, 8'h76, 8'h0A,             // Trap at 8D
        8'h78, 8'h08, 8'h7A, 8'h06, 8'h7C, 8'h04, 8'h7E, 8'h02,
        8'hEB, 8'h02, 8'hE7, 8'hEE, 8'h75, 8'h02, 8'hE7, 8'hEE, 8'hE7, 8'h40,
        8'h3D, 8'h08, 8'h00, 8'h7C, 8'h02, 8'hE7, 8'hEE, 8'h7D, 8'h02, 8'hE7, 8'h41,
        8'h2D, 8'h05, 8'h00, 8'h3D, 8'h00, 8'h00,                           // ZF set
        8'h74, 8'h02, 8'hE7, 8'hEE, 8'h76, 8'h02, 8'hE7, 8'hEE,
        8'h7A, 8'h02, 8'hE7, 8'hEE, 8'h7E, 8'h02, 8'hE7, 8'hEE,
        8'h3D, 8'h00, 8'h80, 8'h70, 8'h02, 8'hE7, 8'hEE, 8'h72, 8'h02, 8'hE7, 8'hEE,
        8'h78, 8'h02, 8'hE7, 8'hEE, 8'hE7, 8'h42,
        8'hF8, 8'hF5, 8'h72, 8'h02, 8'hE7, 8'hEE, 8'hF5, 8'h72, 8'h02, 8'hE7, 8'h43,
        8'hFB, 8'hFA, 8'hFD, 8'hFC, 8'h90, 8'hE4, 8'h34, 8'hE7, 8'h50,      // Port input
        8'hBA, 8'h81, 8'h12, 8'hED, 8'hE7, 8'h51, 8'hE5, 8'h66, 8'hE7, 8'h52,
        8'hEC, 8'hE7, 8'h53, 8'hE7, 8'hFF
    };

    logic [7:0] mem [256];

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = 8'(i * 37) ^ 8'h6B;   // Unused bytes vary with the address
        for (int i = 0; i < progLen; i++)
            mem[i] = progCode[i];
        mem[8'hF0] = 8'hEB;                 // Reset vector, JMP to offset 00
        mem[8'hF1] = 8'h0E;
    end

    assign data = mem[addr[7:0]];

endmodule

/* tb/cpuCoreTb.sv */
`timescale 1ns/1ns

module cpuCoreTb
    import cpuPkg::*;
;

    localparam int clkPeriod   = 4;
    localparam int worstCycles = 375;                           // Whole program, worst case
    localparam int watchdogNs  = 2 * worstCycles * clkPeriod;
    localparam int inCount     = 4;                             // IN instructions in the program

    typedef struct packed {
        logic [15:0] port;
        logic [15:0] value;
        logic        wide;
    } expectT;

    logic        clk25;
    logic        reset;
    logic [7:0]  memData;
    logic [15:0] memAddr;
    logic [15:0] portIn;
    portBusT     ioReq;

    expectT      expList [64];
    int          expCount;
    int          expIdx;
    int          errors;
    int          readCycles;
    logic        finalOutSeen;

    cpuCore cpuCore_i (
        .clk25(clk25), .reset(reset), .memData(memData), .memAddr(memAddr),
        .portIn(portIn), .ioReq(ioReq)
    );

    progRom progRom_i (.addr(memAddr), .data(memData));

    assign portIn = ioReq.portAddr ^ 16'hA5C3;   // Port responder

    initial clk25 = 1'b0;
    always #(clkPeriod / 2) clk25 = ~clk25;

    // ------------------------------------------------------------------------
    // Expected OUT sequence
    // ------------------------------------------------------------------------
    task automatic addExpect(input logic [15:0] port, input logic [15:0] value,
                             input logic wide = 1'b1);
        expList[expCount] = '{port: port, value: value, wide: wide};
        expCount++;
    endtask

    function automatic logic [15:0] signExtByte(input logic [7:0] b);
        return {{8{b[7]}}, b};
    endfunction

    function automatic logic [15:0] responderValue(input logic [15:0] port);
        return port ^ 16'hA5C3;
    endfunction

    initial begin
        logic [15:0] ax;
        logic [15:0] dx;
        logic [15:0] inWord;
        logic [8:0]  diff;
        logic        cf;
        expCount = 0;
        ax = 16'h1234;
        addExpect(16'h0010, ax, 1'b0);        // Byte OUT still carries all of AX
        ax[15:8] = 8'hAB;                     // AH load keeps AL
        addExpect(16'h0011, ax);
        ax = signExtByte(8'h85);
        addExpect(16'h0012, ax);
        dx = {16{ax[15]}};                    // CWD
        addExpect(dx, ax);
        ax = signExtByte(8'h12);
        dx = {16{ax[15]}};
        addExpect(dx, ax);
        dx = 16'h0140;
        addExpect(dx, ax);
        ax = 16'h00F0;
        ax[7:0] = ax[7:0] + 8'h20;
        addExpect(16'h0020, ax);
        ax = ax + 16'h0FF0;
        addExpect(16'h0021, ax);
        ax[7:0] = ax[7:0] | 8'h5A;
        addExpect(16'h0022, ax);
        ax = ax | 16'h2000;
        addExpect(16'h0023, ax);
        ax[7:0] = ax[7:0] + 8'h01 + 8'd1;     // Carry set before ADC
        addExpect(16'h0024, ax);
        ax = ax + 16'h0100 + 16'd1;
        addExpect(16'h0025, ax);
        diff = {1'b0, ax[7:0]} - 9'h060;      // Carry clear, borrows
        ax[7:0] = diff[7:0];
        cf = diff[8];
        addExpect(16'h0026, ax);
        ax = ax - 16'h0100 - {15'd0, cf};
        addExpect(16'h0027, ax);
        ax[7:0] = ax[7:0] & 8'h0F;
        addExpect(16'h0028, ax);
        ax = ax & 16'hFFF0;
        addExpect(16'h0029, ax);
        ax[7:0] = ax[7:0] - 8'h01;
        addExpect(16'h002A, ax);
        ax = ax - 16'h00FF;
        addExpect(16'h002B, ax);
        ax[7:0] = ax[7:0] ^ 8'hA5;
        addExpect(16'h002C, ax);
        ax = ax ^ 16'h30A5;
        addExpect(16'h002D, ax);
        addExpect(16'h002E, ax);              // CMP leaves AX alone
        addExpect(16'h002F, ax);
        ax = ax - 16'd1;
        addExpect(16'h0030, ax);
        ax = ax + 16'd1;
        addExpect(16'h0031, ax);
        addExpect(16'h0032, ax);
        ax = 16'h0005;
        addExpect(16'h0040, ax);
        addExpect(16'h0041, ax);
        ax = ax - 16'h0005;
        addExpect(16'h0042, ax);
        addExpect(16'h0043, ax);
        inWord = responderValue(16'h0034);
        ax[7:0] = inWord[7:0];
        addExpect(16'h0050, ax);
        dx = 16'h1281;
        ax = responderValue(dx);
        addExpect(16'h0051, ax);
        ax = responderValue(16'h0066);
        addExpect(16'h0052, ax);
        inWord = responderValue(dx);
        ax[7:0] = inWord[7:0];
        addExpect(16'h0053, ax);
        addExpect(16'h00FF, ax);
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    outMatchesList: assert property (@(posedge clk25) disable iff (reset)
        ioReq.portWrite |-> (expIdx < expCount && expList[expIdx] ==
                             {ioReq.portAddr, ioReq.portOut, ioReq.portWide}))
    else begin
        errors++;
        $display("[FAIL] %0t OUT #%0d port %h value %h wide %b, expected %h %h %b",
                 $time, $sampled(expIdx), $sampled(ioReq.portAddr), $sampled(ioReq.portOut),
                 $sampled(ioReq.portWide), expList[$sampled(expIdx)].port,
                 expList[$sampled(expIdx)].value, expList[$sampled(expIdx)].wide);
    end

    markerNeverOut: assert property (@(posedge clk25) disable iff (reset)
        ioReq.portWrite |-> ioReq.portAddr != 16'h00EE)
    else begin
        errors++;
        $display("[FAIL] %0t skipped OUT to port 00ee was executed", $time);
    end

    quietInReset: assert property (@(posedge clk25)
        reset && $past(reset) |-> !ioReq.portWrite && !ioReq.portRead)
    else begin
        errors++;
        $display("[FAIL] %0t port strobe active during reset", $time);
    end

    resetVector: assert property (@(posedge clk25)
        reset && $past(reset) |-> memAddr == 16'hFFF0)
    else begin
        errors++;
        $display("[FAIL] %0t memAddr %h during reset, expected fff0", $time, $sampled(memAddr));
    end

    always @(posedge clk25) begin
        if (reset) begin
            expIdx       <= 0;
            readCycles   <= 0;
            finalOutSeen <= 1'b0;
        end else begin
            if (ioReq.portWrite)
                expIdx <= expIdx + 1;
            if (ioReq.portRead)
                readCycles <= readCycles + 1;
            if (ioReq.portWrite && ioReq.portAddr == 16'h00FF)
                finalOutSeen <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------------------
    initial begin
        errors = 0;
        reset  = 1'b1;
        repeat (16) @(posedge clk25);
        reset <= 1'b0;
        wait (finalOutSeen);
        @(negedge clk25);
        allOutputsSeen: assert (expIdx == expCount)
        else begin
            errors++;
            $display("Only %0d of %0d expected outputs were seen", expIdx, expCount);
        end
        onePulsePerIn: assert (readCycles == inCount)
        else begin
            errors++;
            $display("Port read strobe was high %0d cycles for %0d IN instructions",
                     readCycles, inCount);
        end
        $display("Summary: %0d errors, %0d of %0d outputs checked", errors, expIdx, expCount);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog timeout: the test program never reached its final OUT");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* tinyX86.f */
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/flagUnit.sv
hdl/opDecoder.sv
hdl/execSequencer.sv
hdl/cpuCore.sv
tb/progRom.sv
tb/cpuCoreTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpuCoreTb
FILELIST  = tinyX86.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
